//--- common/nn_macros.svh
// Fixed-point word format and lane sizes for the feedforward processor set
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// Signed Q5.10 word
`define NN_WIDTH 16 // Total bits per word
`define NN_FRAC  10 // Fraction bits

// Junction slice handled per accepted beat
`define NN_Z     8 // Activation and weight pairs per beat
`define NN_FI    4 // Fan-in summed into one neuron

// Neurons per beat follow as NN_Z / NN_FI
// The sum tree needs NN_FI to be a power of two

`endif

//--- common/nn_pkg.sv
// Fixed-point types, limits and lane counts shared by the feedforward pipeline
`include "nn_macros.svh"

package nn_pkg;

	// Neurons completed per beat
	localparam int NEURONS = `NN_Z / `NN_FI;

	// Tree adder width
	// Word width plus log2 fan-in plus one bit for the bias add
	localparam int ACC_W = `NN_WIDTH + $clog2(`NN_FI) + 1;

	// Signed Q5.10 word
	typedef logic signed [`NN_WIDTH-1:0] fx_t;

	// Signed accumulator word, wide enough that the tree never wraps
	typedef logic signed [ACC_W-1:0] acc_t;

	// Largest positive word
	localparam fx_t FX_MAX = {1'b0, {(`NN_WIDTH-1){1'b1}}};
	// Most negative word
	localparam fx_t FX_MIN = {1'b1, {(`NN_WIDTH-1){1'b0}}};

	// 1.0 in Q5.10
	localparam fx_t FX_ONE = fx_t'(1 << `NN_FRAC);

endpackage

//--- common/nn_prod_if.sv
// Product and bias channel from the multiply stage to the sum stage
`timescale 1ns/10ps
`include "nn_macros.svh"

interface nn_prod_if;
	import nn_pkg::*;

	logic valid; // Beat present
	logic ready; // Sum stage can take it

	fx_t prod [`NN_Z];   // Saturated products, fi consecutive lanes per neuron
	fx_t bias [NEURONS]; // Biases riding alongside their products

	// Multiply side
	modport src (
		output valid, prod, bias,
		input  ready
	);

	// Sum side
	modport dst (
		input  valid, prod, bias,
		output ready
	);

endinterface

//--- common/nn_sum_if.sv
// Pre-activation channel from the sum stage to the sigmoid stage
`timescale 1ns/10ps

interface nn_sum_if;
	import nn_pkg::*;

	logic valid; // Beat present
	logic ready; // Sigmoid stage can take it

	// Clamped pre-activation per neuron
	fx_t sum [NEURONS];

	// Set where the neuron sum was clamped
	logic [NEURONS-1:0] sat;

	modport src (
		output valid, sum, sat,
		input  ready
	);

	modport dst (
		input  valid, sum, sat,
		output ready
	);

endinterface

//--- ff_processor/ff_mul_stage.sv
// First pipeline stage, z saturating Q5.10 multipliers with a registered output
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_mul_stage (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             valid_i,                   // Beat offered
	output logic             ready_o,                   // Beat taken when high with valid_i
	input  nn_pkg::fx_t      act_i  [`NN_Z],            // Activations
	input  nn_pkg::fx_t      wt_i   [`NN_Z],            // Weights
	input  nn_pkg::fx_t      bias_i [nn_pkg::NEURONS],  // One bias per neuron
	nn_prod_if.src           out
);
	import nn_pkg::*;

	// Full product width of two words
	localparam int PROD_W = 2 * `NN_WIDTH;

	logic signed [PROD_W-1:0] full_prod  [`NN_Z]; // Q10.20 product
	logic signed [PROD_W-1:0] shift_prod [`NN_Z]; // Back to Q.10 scale
	fx_t                      sat_prod   [`NN_Z]; // Clamped to word range
	logic                     load;

	// Register is free when empty or draining this cycle
	assign ready_o = !out.valid || out.ready;
	assign load    = valid_i && ready_o;

	always_comb
	begin
		for (int k = 0; k < `NN_Z; k++)
		begin
			full_prod[k]  = act_i[k] * wt_i[k];        // Signed 16x16
			shift_prod[k] = full_prod[k] >>> `NN_FRAC; // Floor toward minus infinity
			if (shift_prod[k] > FX_MAX)
				sat_prod[k] = FX_MAX;
			else if (shift_prod[k] < FX_MIN)
				sat_prod[k] = FX_MIN;
			else
				sat_prod[k] = fx_t'(shift_prod[k]); // Fits, keep low word
		end
	end

	// Stage valid
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			out.valid <= 1'b0;
		else if (ready_o)
			out.valid <= valid_i; // Fill, refill or empty
	end

	// Payload, loaded only on a transfer
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			out.prod <= sat_prod;
			out.bias <= bias_i; // Bias travels with its products
		end
	end

endmodule

//--- ff_processor/ff_sum_stage.sv
// Second pipeline stage, per-neuron tree adder with bias add and saturation
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_sum_stage (
	input  logic    clk,
	input  logic    rst_n_i,
	nn_prod_if.dst  in,  // Products and biases from the multipliers
	nn_sum_if.src   out  // Clamped sums toward the sigmoid
);
	import nn_pkg::*;

	acc_t               ext      [`NN_Z];      // Sign-extended products
	acc_t               pair_sum [NEURONS][2]; // First tree level
	acc_t               tree_sum [NEURONS];    // Second tree level
	acc_t               raw_sum  [NEURONS];    // With bias
	fx_t                clamp_sum [NEURONS];
	logic [NEURONS-1:0] clamp_flag;
	logic               load;

	// Same rule as every stage, free when empty or draining
	assign in.ready = !out.valid || out.ready;
	assign load     = in.valid && in.ready;

	always_comb
	begin
		for (int k = 0; k < `NN_Z; k++)
			ext[k] = acc_t'(in.prod[k]); // Signed cast extends the sign

		for (int n = 0; n < NEURONS; n++)
		begin
			// Two adders on the first level
			pair_sum[n][0] = ext[n*`NN_FI]     + ext[n*`NN_FI + 1];
			pair_sum[n][1] = ext[n*`NN_FI + 2] + ext[n*`NN_FI + 3];
			tree_sum[n]    = pair_sum[n][0] + pair_sum[n][1];

			raw_sum[n] = tree_sum[n] + acc_t'(in.bias[n]); // Cannot wrap at ACC_W

			// Clamp to the nearer limit and flag it
			if (raw_sum[n] > FX_MAX)
			begin
				clamp_sum[n]  = FX_MAX;
				clamp_flag[n] = 1'b1;
			end
			else if (raw_sum[n] < FX_MIN)
			begin
				clamp_sum[n]  = FX_MIN;
				clamp_flag[n] = 1'b1;
			end
			else
			begin
				clamp_sum[n]  = fx_t'(raw_sum[n]);
				clamp_flag[n] = 1'b0;
			end
		end
	end

	// Valid and flags are cleared by reset
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			out.valid <= 1'b0;
			out.sat   <= '0;
		end
		else
		begin
			if (in.ready)
				out.valid <= in.valid;
			if (load)
				out.sat <= clamp_flag; // Flags follow their sums
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			out.sum <= clamp_sum;
	end

endmodule

//--- ff_processor/ff_sigmoid_stage.sv
// Third pipeline stage, piecewise-linear sigmoid and its derivative per neuron
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_sigmoid_stage (
	input  logic                         clk,
	input  logic                         rst_n_i,
	nn_sum_if.dst                        in,
	output logic                         valid_o,
	input  logic                         ready_i,
	output nn_pkg::fx_t                  act_o  [nn_pkg::NEURONS], // Sigmoid
	output nn_pkg::fx_t                  adot_o [nn_pkg::NEURONS], // Sigmoid prime
	output logic [nn_pkg::NEURONS-1:0]   sat_o                     // Pre-activation clamped
);
	import nn_pkg::*;

	// Segment breakpoints and offsets, all exact in Q5.10
	localparam fx_t A_TOP   = fx_t'(5 << `NN_FRAC);         // 5.0
	localparam fx_t A_MID   = fx_t'((19 << `NN_FRAC) / 8);  // 2.375
	localparam fx_t OFS_HI  = fx_t'((27 << `NN_FRAC) / 32); // 0.84375
	localparam fx_t OFS_MID = fx_t'((5 << `NN_FRAC) / 8);   // 0.625
	localparam fx_t OFS_LO  = fx_t'(FX_ONE / 2);            // 0.5

	logic signed [`NN_WIDTH:0]     mag       [NEURONS]; // |x| with room for -FX_MIN
	fx_t                           a         [NEURONS];
	fx_t                           y         [NEURONS]; // Positive-side value
	fx_t                           act_d     [NEURONS];
	logic signed [2*`NN_WIDTH-1:0] adot_prod [NEURONS];
	fx_t                           adot_d    [NEURONS];
	logic                          load;

	assign in.ready = !valid_o || ready_i;
	assign load     = in.valid && in.ready;

	always_comb
	begin
		for (int n = 0; n < NEURONS; n++)
		begin
			mag[n] = in.sum[n][`NN_WIDTH-1] ? -{in.sum[n][`NN_WIDTH-1], in.sum[n]}
			                                : {1'b0, in.sum[n]};
			a[n] = (mag[n] > FX_MAX) ? FX_MAX : fx_t'(mag[n]); // Only FX_MIN lands here

			if (a[n] >= A_TOP)
				y[n] = FX_ONE; // Flat top
			else if (a[n] >= A_MID)
				y[n] = (a[n] >>> 5) + OFS_HI;
			else if (a[n] >= FX_ONE)
				y[n] = (a[n] >>> 3) + OFS_MID;
			else
				y[n] = (a[n] >>> 2) + OFS_LO; // Steepest segment around zero

			act_d[n] = in.sum[n][`NN_WIDTH-1] ? FX_ONE - y[n] : y[n]; // Odd symmetry about 0.5

			// act * (1 - act), both in [0, 1]
			adot_prod[n] = act_d[n] * (FX_ONE - act_d[n]);
			adot_d[n]    = fx_t'(adot_prod[n] >>> `NN_FRAC);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			valid_o <= 1'b0;
			sat_o   <= '0;
		end
		else
		begin
			if (in.ready)
				valid_o <= in.valid;
			if (load)
				sat_o <= in.sat; // Passed through untouched
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			act_o  <= act_d;
			adot_o <= adot_d;
		end
	end

endmodule

//--- source/ff_processor_top.sv
// Feedforward processor set top, three registered stages with flattened ports
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_processor_top (
	input  logic                                   clk,
	input  logic                                   rst_n_i,
	input  logic                                   in_valid_i,
	output logic                                   in_ready_o,
	input  logic [`NN_Z*`NN_WIDTH-1:0]             act_i,  // Lane k at bits k*16 upward
	input  logic [`NN_Z*`NN_WIDTH-1:0]             wt_i,
	input  logic [nn_pkg::NEURONS*`NN_WIDTH-1:0]   bias_i, // One word per neuron
	output logic                                   valid_o,
	input  logic                                   ready_i,
	output logic [nn_pkg::NEURONS*`NN_WIDTH-1:0]   act_o,
	output logic [nn_pkg::NEURONS*`NN_WIDTH-1:0]   adot_o,
	output logic [nn_pkg::NEURONS-1:0]             sat_o
);
	import nn_pkg::*;

	fx_t act_w  [`NN_Z];
	fx_t wt_w   [`NN_Z];
	fx_t bias_w [NEURONS];
	fx_t act_q  [NEURONS];
	fx_t adot_q [NEURONS];

	// Unpack the input lanes
	for (genvar k = 0; k < `NN_Z; k++)
	begin : g_lane
		assign act_w[k] = act_i[k*`NN_WIDTH +: `NN_WIDTH];
		assign wt_w[k]  = wt_i[k*`NN_WIDTH +: `NN_WIDTH];
	end

	// Per-neuron words in and out
	for (genvar n = 0; n < NEURONS; n++)
	begin : g_neuron
		assign bias_w[n]                    = bias_i[n*`NN_WIDTH +: `NN_WIDTH];
		assign act_o[n*`NN_WIDTH +: `NN_WIDTH]  = act_q[n];
		assign adot_o[n*`NN_WIDTH +: `NN_WIDTH] = adot_q[n];
	end

	nn_prod_if prod_if ();
	nn_sum_if  sum_if ();

	ff_mul_stage mul_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.valid_i(in_valid_i), .ready_o(in_ready_o),
		.act_i(act_w), .wt_i(wt_w), .bias_i(bias_w),
		.out(prod_if.src)
	);

	ff_sum_stage sum_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.in(prod_if.dst), .out(sum_if.src)
	);

	ff_sigmoid_stage sig_i (
		.clk(clk), .rst_n_i(rst_n_i),
		.in(sum_if.dst),
		.valid_o(valid_o), .ready_i(ready_i),
		.act_o(act_q), .adot_o(adot_q), .sat_o(sat_o)
	);

endmodule

//--- bench/ff_processor_props.sv
// Output handshake and reset properties of the feedforward processor top
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_processor_props (
	input logic                                 clk,
	input logic                                 rst_n_i,
	input logic                                 in_ready_o,
	input logic                                 valid_o,
	input logic                                 ready_i,
	input logic [nn_pkg::NEURONS*`NN_WIDTH-1:0] act_o,
	input logic [nn_pkg::NEURONS*`NN_WIDTH-1:0] adot_o,
	input logic [nn_pkg::NEURONS-1:0]           sat_o
);

	// A reset edge empties the output register
	reset_empty: assert property (@(posedge clk) !rst_n_i |=> !valid_o)
		else $error("valid_o high after a reset edge");

	// Stalled beat holds until taken
	held_while_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o && !ready_i |=> valid_o && $stable(act_o) && $stable(adot_o) && $stable(sat_o))
		else $error("Output beat changed while stalled");

	ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
		!valid_o |-> in_ready_o) // Empty output means the whole chain can move
		else $error("in_ready_o low with an empty output stage");

endmodule

bind ff_processor_top ff_processor_props props_i (.*);

//--- bench/ff_processor_tb.sv
// Feedforward processor testbench with directed table, random beats and in-order scoreboard
`timescale 1ns/10ps
`include "nn_macros.svh"

module ff_processor_tb;
	import nn_pkg::*;

	localparam int VW      = `NN_Z * `NN_WIDTH;
	localparam int NW      = NEURONS * `NN_WIDTH;
	localparam int EW      = 2 * NW + NEURONS; // Expected beat packed as {sat, adot, act}
	localparam int N_DIR   = 5;
	localparam int N_RAND  = 200;
	localparam int TIMEOUT = 100;              // Cycles allowed per wait
	localparam longint ONE = longint'(FX_ONE);

	typedef struct packed {
		logic [VW-1:0]      act;
		logic [VW-1:0]      wt;
		logic [NW-1:0]      bias;
		logic [NW-1:0]      e_act;
		logic [NW-1:0]      e_adot;
		logic [NEURONS-1:0] e_sat;
	} row_t;

	logic               clk        = 1'b0;
	logic               rst_n_i    = 1'b0;
	logic               in_valid_i = 1'b0;
	logic               in_ready_o;
	logic [VW-1:0]      act_i      = '0;
	logic [VW-1:0]      wt_i       = '0;
	logic [NW-1:0]      bias_i     = '0;
	logic               valid_o;
	logic               ready_i    = 1'b1;
	logic [NW-1:0]      act_o;
	logic [NW-1:0]      adot_o;
	logic [NEURONS-1:0] sat_o;

	row_t          tbl [N_DIR];
	logic [EW-1:0] exp_q [$];    // Expected beats in input order
	logic [EW-1:0] exp_b;
	logic [VW-1:0] rnd_act;
	logic [VW-1:0] rnd_wt;
	logic [NW-1:0] rnd_bias;
	integer        seed = 32'hac8b_11b4;
	integer        rdy_rnd;
	logic          ready_nxt;
	int            cyc = 0;
	int            first_in_cyc;
	int            n_in = 0;
	int            n_out = 0;
	int            stall = 0;     // Forced low ready cycles
	int            waits;
	bit            rand_phase = 1'b0;
	bit            saw_full = 1'b0;

	ff_processor_top dut_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// Next ready level is picked at the edge and driven 1 ns later
	always @(posedge clk)
	begin
		if (stall > 0)
		begin
			ready_nxt = 1'b0;
			stall--;
		end
		else if (rand_phase)
		begin
			rdy_rnd   = $random(seed);
			ready_nxt = rdy_rnd[0]; // Random back-pressure
		end
		else
			ready_nxt = 1'b1;
		#1;
		ready_i = ready_nxt;
	end

	task automatic stop_on_error;
		$display("Simulation finished: FAIL");
		$fatal(1, "Testbench stopped on the first error");
	endtask

	function automatic longint clamp_word(input longint v);
		if (v > longint'(FX_MAX))
			return longint'(FX_MAX);
		if (v < longint'(FX_MIN))
			return longint'(FX_MIN);
		return v;
	endfunction

	// Reference model of the multiply, tree sum, clamp and sigmoid rules
	function automatic logic [EW-1:0] model_beat(input logic [VW-1:0] a, input logic [VW-1:0] w,
		input logic [NW-1:0] b);
		longint        x;
		longint        p;
		longint        m;
		longint        y;
		longint        act;
		longint        adot;
		logic [EW-1:0] r;
		int            k;
		r = '0;
		for (int n = 0; n < NEURONS; n++)
		begin
			x = longint'($signed(b[n*`NN_WIDTH +: `NN_WIDTH]));
			for (int j = 0; j < `NN_FI; j++)
			begin
				k = n * `NN_FI + j;
				p = longint'($signed(a[k*`NN_WIDTH +: `NN_WIDTH]))
				  * longint'($signed(w[k*`NN_WIDTH +: `NN_WIDTH]));
				x = x + clamp_word(p >>> `NN_FRAC); // Floor, then clamp each product
			end
			r[2*NW + n] = (clamp_word(x) != x);
			x = clamp_word(x);
			m = (x < 0) ? -x : x;
			if (m > longint'(FX_MAX))
				m = longint'(FX_MAX);
			if (m >= 5 * ONE)
				y = ONE;
			else if (m >= (19 * ONE) / 8)
				y = m / 32 + (27 * ONE) / 32; // 0.84375 offset
			else if (m >= ONE)
				y = m / 8 + (5 * ONE) / 8;
			else
				y = m / 4 + ONE / 2;
			act  = (x < 0) ? ONE - y : y;
			adot = (act * (ONE - act)) >>> `NN_FRAC;
			r[n*`NN_WIDTH +: `NN_WIDTH]      = act[`NN_WIDTH-1:0];
			r[NW + n*`NN_WIDTH +: `NN_WIDTH] = adot[`NN_WIDTH-1:0];
		end
		return r;
	endfunction

	// Random lanes scaled down by an arithmetic shift
	function automatic logic [VW-1:0] rand_lanes(input int lanes, input int shift);
		logic [VW-1:0] v;
		fx_t           word;
		v = '0;
		for (int k = 0; k < lanes; k++)
		begin
			word = fx_t'($random(seed));
			v[k*`NN_WIDTH +: `NN_WIDTH] = word >>> shift;
		end
		return v;
	endfunction

	task automatic send_beat(input logic [VW-1:0] a, input logic [VW-1:0] w,
		input logic [NW-1:0] b, input logic [EW-1:0] e);
		int tries;
		tries = 0;
		act_i      = a;
		wt_i       = w;
		bias_i     = b;
		in_valid_i = 1'b1;
		@(posedge clk);
		while (!in_ready_o)
		begin
			tries++;
			if (tries > TIMEOUT)
			begin
				$display("Timeout at %0t, in_ready_o stayed low", $time);
				stop_on_error();
			end
			@(posedge clk);
		end
		if (n_in == 0)
			first_in_cyc = cyc; // Input transfer edge of the first beat
		n_in++;
		exp_q.push_back(e);
		#1;
		in_valid_i = 1'b0;
	endtask

	// Scoreboard on every output transfer
	always @(posedge clk)
	begin
		if (rst_n_i && valid_o && ready_i)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Output beat at %0t with no input beat behind it", $time);
				stop_on_error();
			end
			exp_b = exp_q.pop_front();
			assert (act_o === exp_b[NW-1:0]) else
			begin
				$display("Fail at %0t: act_o is %h, expected %h", $time, act_o, exp_b[NW-1:0]);
				stop_on_error();
			end
			assert (adot_o === exp_b[2*NW-1:NW]) else
			begin
				$display("Fail at %0t: adot_o is %h, expected %h", $time, adot_o,
					exp_b[2*NW-1:NW]);
				stop_on_error();
			end
			assert (sat_o === exp_b[EW-1:2*NW]) else
			begin
				$display("Fail at %0t: sat_o is %b, expected %b", $time, sat_o, exp_b[EW-1:2*NW]);
				stop_on_error();
			end
			if (n_out == 0)
			begin
				assert (cyc - first_in_cyc == 3) else
				begin
					$display("Fail at %0t: latency is %0d, expected 3", $time, cyc - first_in_cyc);
					stop_on_error();
				end
			end
			n_out++;
		end
		if (rst_n_i && !in_ready_o)
			saw_full = 1'b1; // Pipeline full under back-pressure
	end

	initial
	begin
		// Positive segments a < 1 and 1 <= a < 2.375
		tbl[0] = '{128'h0000_0000_0000_0800_0000_0000_0000_0400,
			128'h0000_0000_0000_0300_0000_0000_0000_0200,
			32'h0080_0000, 32'h0350_0280, 32'h0091_00f0, 2'b00};
		// Full tree with 2.375 <= a < 5 on both sides
		tbl[1] = '{128'h0800_0800_0800_0800_0400_0400_0400_0400,
			128'hfe00_fe00_fe00_fe00_0100_0100_0100_0100,
			32'h0000_0600, 32'h0020_03b0, 32'h001f_0049, 2'b00};
		// a >= 5 and a small negative sum with a floored product
		tbl[2] = '{128'h0000_0000_0003_0001_0000_0000_0000_1800,
			128'h0000_0000_0155_ffff_0000_0000_0000_0400,
			32'hff00_0000, 32'h01c0_0400, 32'h00fc_0000, 2'b00};
		// Sum clamped high and low
		tbl[3] = '{128'h8000_8000_8000_8000_0000_0000_0000_7fff,
			128'h0400_0400_0400_0400_0000_0000_0000_7fff,
			32'h8000_0400, 32'h0000_0400, 32'h0000_0000, 2'b11};
		// Products clamped before the sum and a negative 1 <= a < 2.375
		tbl[4] = '{128'h0000_0000_0000_0400_0000_0000_8000_7fff,
			128'h0000_0000_0000_fa00_0000_0000_7fff_7fff,
			32'h0000_0000, 32'h00c0_0200, 32'h009c_0100, 2'b00};

		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			if (i > 0)
			begin
				assert (valid_o === 1'b0) else
				begin
					$display("Fail at %0t: valid_o is %b, expected 0", $time, valid_o);
					stop_on_error();
				end
			end
		end
		#1;
		rst_n_i = 1'b1;

		for (int i = 0; i < N_DIR; i++)
			send_beat(tbl[i].act, tbl[i].wt, tbl[i].bias,
				{tbl[i].e_sat, tbl[i].e_adot, tbl[i].e_act});

		stall      = 6; // Long enough to fill all three stages
		rand_phase = 1'b1;
		for (int i = 0; i < N_RAND; i++)
		begin
			rnd_act  = rand_lanes(`NN_Z, 4);
			rnd_wt   = rand_lanes(`NN_Z, 3);
			rnd_bias = NW'(rand_lanes(NEURONS, 2));
			send_beat(rnd_act, rnd_wt, rnd_bias, model_beat(rnd_act, rnd_wt, rnd_bias));
		end
		rand_phase = 1'b0;

		waits = 0;
		while (exp_q.size() != 0)
		begin
			waits++;
			if (waits > TIMEOUT)
			begin
				$display("Timeout at %0t, expected beats never came out", $time);
				stop_on_error();
			end
			@(posedge clk);
		end
		@(posedge clk);
		assert (saw_full) else
		begin
			$display("in_ready_o never fell while the output was stalled");
			stop_on_error();
		end
		if (valid_o !== 1'b0)
		begin
			$display("Fail at %0t: valid_o is %b, expected 0 after drain", $time, valid_o);
			stop_on_error();
		end
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

//--- flist.f
+incdir+common
common/nn_pkg.sv
common/nn_prod_if.sv
common/nn_sum_if.sv
ff_processor/ff_mul_stage.sv
ff_processor/ff_sum_stage.sv
ff_processor/ff_sigmoid_stage.sv
source/ff_processor_top.sv
bench/ff_processor_props.sv
bench/ff_processor_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the feedforward processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ff_processor_tb \
	-f flist.f -o ff_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ff_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit $status
fi
exit 0
